//--- Bender.yml
package:
  name: text_renderer

sources:
  - renderPkg.sv
  - glyphRom.sv
  - lineGen.sv
  - glyphStyle.sv
  - inkMask.sv
  - renderCtrl.sv
  - textRenderer.sv
  - target: simulation
    files:
      - renderChecker.sv
      - tbTextRenderer.sv

//--- glyphRom.sv
module glyphRom (
	input logic clk,
	input logic en,
	input renderPkg::charCode code,
	input renderPkg::scanRow row,
	output renderPkg::pixelRow glyph
);

	logic [7:0] lowByte;

	// a fixed rule takes the place of font data, so every row is predictable.
	assign lowByte = {~code[7:4], code[3:0] ^ row};

	// one cycle of read latency, like a synchronous font memory.
	always_ff @(posedge clk) begin
		if (en) begin
			glyph <= {code, lowByte};
		end
	end

endmodule

//--- glyphStyle.sv
module glyphStyle (
	input renderPkg::pixelRow glyph,
	input renderPkg::attrWord attr,
	input renderPkg::modeWord mode,
	input renderPkg::scanRow effectRow,
	output renderPkg::pixelRow styled
);

	import renderPkg::*;

	pixelRow preRow;
	pixelRow slantRow;
	pixelRow boldRow;
	pixelRow offsetRow;
	pixelRow scaleRow;
	logic italicOnly;
	logic reverseOnly;

	assign preRow = mode[modeXPreMirror] ? mirrorRow(glyph) : glyph;

	assign italicOnly = attr[attrItalic] & ~attr[attrReverseItalic];
	assign reverseOnly = attr[attrReverseItalic] & ~attr[attrItalic];

	// the slant steps once every four scanlines, top rows lean furthest.
	always_comb begin
		slantRow = preRow;
		if (italicOnly) begin
			case (effectRow[3:2])
				2'd0: slantRow = preRow >> 2;
				2'd1: slantRow = preRow >> 1;
				2'd2: slantRow = preRow;
				default: slantRow = preRow << 1;
			endcase
		end else if (reverseOnly) begin
			case (effectRow[3:2])
				2'd0: slantRow = preRow << 2;
				2'd1: slantRow = preRow << 1;
				2'd2: slantRow = preRow;
				default: slantRow = preRow >> 1;
			endcase
		end
	end

	always_comb begin
		boldRow = slantRow;
		if (attr[attrBold]) begin
			boldRow = slantRow | (slantRow >> 1);
			if (attr[attrExtraBold])
				boldRow = boldRow | (slantRow << 1);
		end
	end

	assign offsetRow = attr[attrXOffset] ? {slantSwap(boldRow)} : boldRow;

	// only the left half survives a horizontal scale.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			scaleRow[15 - 2 * i] = offsetRow[15 - i];
			scaleRow[14 - 2 * i] = offsetRow[15 - i];
		end
	end

	assign styled = attr[attrXScale] ? scaleRow : offsetRow;

	function automatic pixelRow slantSwap(input pixelRow r);
		return {r[7:0], r[15:8]};
	endfunction

endmodule

//--- inkMask.sv
module inkMask (
	input renderPkg::pixelRow styled,
	input renderPkg::attrWord attr,
	input renderPkg::modeWord mode,
	input logic blinkPhase,
	input logic inverse,
	input logic faint,
	input logic faintPhase,
	input logic solidLine,
	output renderPkg::pixelRow pixels
);

	import renderPkg::*;

	pixelRow lineRow;
	pixelRow faintRow;
	pixelRow hiddenRow;
	pixelRow blinkRow;
	pixelRow altRow;
	pixelRow invRow;
	logic blinkOff;
	logic altOn;

	assign lineRow = solidLine ? 16'hFFFF : styled;

	// faint keeps every other pixel, the phase picks which half.
	assign faintRow = faint ? (lineRow & (faintPhase ? 16'h5555 : 16'hAAAA)) : lineRow;
	assign hiddenRow = attr[attrHidden] ? 16'h0000 : faintRow;

	assign blinkOff = attr[attrBlink] & blinkPhase & mode[modeBlinkEnable];
	assign blinkRow = blinkOff ? 16'h0000 : hiddenRow;

	// with blinking disabled the alternate colour is shown all the time.
	assign altOn = attr[attrAlternate] & (blinkPhase | ~mode[modeBlinkEnable]);
	assign altRow = altOn ? ~blinkRow : blinkRow;

	assign invRow = inverse ? ~altRow : altRow;
	assign pixels = mode[modeXPostMirror] ? mirrorRow(invRow) : invRow;

endmodule

//--- lineGen.sv
module lineGen (
	input renderPkg::scanRow scanline,
	input renderPkg::attrWord attr,
	input renderPkg::modeWord mode,
	input logic faintPhase,
	input logic cursorPhase,
	output renderPkg::scanRow bitmapRow,
	output renderPkg::scanRow effectRow,
	output logic inverseOut,
	output logic faintOut,
	output logic faintPhaseOut,
	output logic solidLine
);

	import renderPkg::*;

	scanRow postRow;
	scanRow scaledRow;
	logic underRow;
	logic strikeRow;
	logic overRow;
	logic underHit;
	logic strikeHit;
	logic overHit;
	logic dottedHit;
	logic cursorRowOk;
	logic cursorOn;

	assign postRow = mode[modeYPostMirror] ? ~scanline : scanline;
	assign scaledRow = attr[attrYScale] ? {1'b0, postRow[3:1]} : postRow;
	assign effectRow = attr[attrYOffset] ? {~scaledRow[3], scaledRow[2:0]} : scaledRow;
	assign bitmapRow = mode[modeYPreMirror] ? ~effectRow : effectRow;

	// the double form moves or adds rows depending on whether the single bit is also set.
	always_comb begin
		if (attr[attrDoubleUnderline] && attr[attrUnderline])
			underRow = (effectRow == 4'd15);
		else if (attr[attrDoubleUnderline])
			underRow = (effectRow == 4'd13) || (effectRow == 4'd15);
		else
			underRow = (effectRow == 4'd13);

		if (attr[attrDoubleStrike] && attr[attrStrike])
			strikeRow = (effectRow == 4'd5) || (effectRow == 4'd7) || (effectRow == 4'd9);
		else if (attr[attrDoubleStrike])
			strikeRow = (effectRow == 4'd6) || (effectRow == 4'd8);
		else
			strikeRow = (effectRow == 4'd7);

		if (attr[attrDoubleOverline] && attr[attrOverline])
			overRow = (effectRow == 4'd2);
		else if (attr[attrDoubleOverline])
			overRow = (effectRow == 4'd0) || (effectRow == 4'd2);
		else
			overRow = (effectRow == 4'd0);
	end

	assign underHit = mode[modeLineEnable] & underRow &
		(attr[attrUnderline] | attr[attrDoubleUnderline] | attr[attrDottedUnderline]);
	assign strikeHit = mode[modeLineEnable] & strikeRow &
		(attr[attrStrike] | attr[attrDoubleStrike] | attr[attrDottedStrike]);
	assign overHit = mode[modeLineEnable] & overRow &
		(attr[attrOverline] | attr[attrDoubleOverline] | attr[attrDottedOverline]);

	assign dottedHit = (underHit & attr[attrDottedUnderline]) |
		(strikeHit & attr[attrDottedStrike]) | (overHit & attr[attrDottedOverline]);
	assign solidLine = underHit | strikeHit | overHit;

	// cursor rows are judged on the incoming scanline, before any transform.
	assign cursorRowOk = !(mode[modeCursorTop] || mode[modeCursorBottom]) ||
		(mode[modeCursorTop] && (scanline < 4'd3)) ||
		(mode[modeCursorBottom] && (scanline > 4'd12));
	assign cursorOn = attr[attrCursor] & (cursorPhase | ~mode[modeCursorBlink]) & cursorRowOk;

	assign inverseOut = attr[attrInverse] ^ cursorOn;
	assign faintOut = attr[attrFaint] | dottedHit;
	assign faintPhaseOut = faintPhase ^ scaledRow[0];

endmodule

//--- renderChecker.sv
module renderChecker (
	input logic clk,
	input logic arstN,
	input logic req,
	input logic ack,
	input renderPkg::pixelRow pixels,
	input renderPkg::pixelRow expected,
	output int errors,
	output int checks
);

	timeunit 1ns;
	timeprecision 100ps;

	import renderPkg::*;

	int errorCount = 0;
	int checkCount = 0;
	int cycles = 0;
	logic afterReset = 1'b0;
	logic waiting = 1'b0;
	logic inHold = 1'b0;
	logic dropping = 1'b0;
	pixelRow holdRow;

	assign errors = errorCount;
	assign checks = checkCount;

	task automatic flagError(input string msg);
		errorCount++;
		$display("ERR %0t ns: %s", $time, msg);
	endtask

	// values are taken just before the edge, the same view the DUT has.
	always @(posedge clk) begin
		if (!arstN) begin
			afterReset = 1'b1;
			waiting = 1'b0;
			inHold = 1'b0;
			dropping = 1'b0;
		end else begin
			if (afterReset) begin
				checkCount++;
				if (ack !== 1'b0 || pixels !== 16'h0000)
					flagError($sformatf("after reset ack=%b pixels=%h", ack, pixels));
				afterReset = 1'b0;
			end
			if (dropping) begin
				checkCount++;
				if (ack !== 1'b0)
					flagError("ack still high one edge after req dropped");
				dropping = 1'b0;
			end else if (inHold) begin
				checkCount++;
				if (ack !== 1'b1)
					flagError("ack fell while req was still high");
				if (pixels !== holdRow)
					flagError($sformatf("pixels moved to %h during hold, was %h", pixels, holdRow));
				if (!req) begin
					inHold = 1'b0;
					dropping = 1'b1;
				end
			end else if (waiting) begin
				cycles++;
				if (ack === 1'b1) begin
					checkCount += 2;
					// ack is registered two edges after the one that took req and shows up
					// here on the third.
					if (cycles != 3)
						flagError($sformatf("ack seen %0d edges after req was taken, not 3",
							cycles));
					if (pixels !== expected)
						flagError($sformatf("pixels %h, expected %h", pixels, expected));
					holdRow = pixels;
					inHold = 1'b1;
					waiting = 1'b0;
				end else if (cycles >= 3) begin
					flagError("ack later than 3 cycles after req");
					waiting = 1'b0;
				end
			end else if (req && !ack) begin
				waiting = 1'b1;
				cycles = 0;
			end
		end
	end

endmodule

//--- renderCtrl.sv
module renderCtrl (
	input logic clk,
	input logic arstN,
	input logic req,
	output logic ack,
	input renderPkg::charCode code,
	input renderPkg::attrWord attr,
	input renderPkg::scanRow scanline,
	input renderPkg::modeWord mode,
	input logic frameTick,
	input renderPkg::pixelRow styledRow,
	output renderPkg::charCode codeQ,
	output renderPkg::attrWord attrQ,
	output renderPkg::scanRow scanlineQ,
	output renderPkg::modeWord modeQ,
	output logic romEn,
	output logic blinkPhase,
	output logic cursorPhase,
	output logic faintPhase,
	output renderPkg::pixelRow pixels
);

	import renderPkg::*;

	ctrlState state;
	logic [frameBits-1:0] frameCount;
	logic accept;

	assign accept = (state == idle) && req;
	assign romEn = (state == fetch);

	// one cell at a time: latch, read glyph, style, then hold until req drops.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			ack <= 1'b0;
			pixels <= '0;
		end else begin
			case (state)
				idle: begin
					if (req)
						state <= fetch;
				end
				fetch: state <= style;
				style: begin
					state <= hold;
					ack <= 1'b1;
					pixels <= styledRow;
				end
				hold: begin
					if (!req) begin
						state <= done;
						ack <= 1'b0;
					end
				end
				done: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			frameCount <= '0;
		else if (frameTick)
			frameCount <= frameCount + 1'b1;
	end

	// phases are taken together with the operands so a cell sees one frame.
	always_ff @(posedge clk) begin
		if (accept) begin
			codeQ <= code;
			attrQ <= attr;
			scanlineQ <= scanline;
			modeQ <= mode;
			blinkPhase <= frameCount[blinkPhaseBit];
			cursorPhase <= frameCount[cursorPhaseBit];
			faintPhase <= frameCount[faintPhaseBit];
		end
	end

endmodule

//--- renderPkg.sv
package renderPkg;

	typedef logic [7:0] charCode;
	typedef logic [3:0] scanRow;
	typedef logic [15:0] pixelRow;
	typedef logic [23:0] attrWord;
	typedef logic [9:0] modeWord;

	// bit positions inside the attribute word, bit 23 is reserved.
	localparam int attrBold = 0;
	localparam int attrExtraBold = 1;
	localparam int attrFaint = 2;
	localparam int attrItalic = 3;
	localparam int attrReverseItalic = 4;
	localparam int attrBlink = 5;
	localparam int attrAlternate = 6;
	localparam int attrInverse = 7;
	localparam int attrHidden = 8;
	localparam int attrUnderline = 9;
	localparam int attrDoubleUnderline = 10;
	localparam int attrDottedUnderline = 11;
	localparam int attrStrike = 12;
	localparam int attrDoubleStrike = 13;
	localparam int attrDottedStrike = 14;
	localparam int attrOverline = 15;
	localparam int attrDoubleOverline = 16;
	localparam int attrDottedOverline = 17;
	localparam int attrCursor = 18;
	localparam int attrXOffset = 19;
	localparam int attrXScale = 20;
	localparam int attrYOffset = 21;
	localparam int attrYScale = 22;

	// bit positions inside the mode word, bit 9 is reserved.
	localparam int modeXPreMirror = 0;
	localparam int modeXPostMirror = 1;
	localparam int modeYPreMirror = 2;
	localparam int modeYPostMirror = 3;
	localparam int modeBlinkEnable = 4;
	localparam int modeLineEnable = 5;
	localparam int modeCursorBlink = 6;
	localparam int modeCursorTop = 7;
	localparam int modeCursorBottom = 8;

	// each phase is one bit of the frame counter.
	localparam int frameBits = 6;
	localparam int blinkPhaseBit = 5;
	localparam int cursorPhaseBit = 4;
	localparam int faintPhaseBit = 0;

	typedef enum logic [2:0] {
		idle,
		fetch,
		style,
		hold,
		done
	} ctrlState;

	// swaps left and right pixels of a row.
	function automatic pixelRow mirrorRow(input pixelRow r);
		pixelRow m;
		for (int i = 0; i < 16; i++) begin
			m[i] = r[15 - i];
		end
		return m;
	endfunction

endpackage

//--- sources.f
renderPkg.sv
glyphRom.sv
lineGen.sv
glyphStyle.sv
inkMask.sv
renderCtrl.sv
textRenderer.sv
renderChecker.sv
tbTextRenderer.sv

//--- tbTextRenderer.sv
module tbTextRenderer;

	timeunit 1ns;
	timeprecision 100ps;

	import renderPkg::*;

	localparam int ackLimit = 20;

	logic clk = 1'b0;
	logic arstN;
	logic req;
	logic ack;
	charCode code;
	attrWord attr;
	scanRow scanline;
	modeWord mode;
	logic frameTick;
	pixelRow pixels;
	pixelRow expected;
	int errors;
	int checks;
	int timeouts = 0;
	int frames = 0;
	int i;
	int row;
	int stage;
	attrWord lineAttr;
	modeWord lineMode;

	textRenderer dut0 (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.ack(ack),
		.code(code),
		.attr(attr),
		.scanline(scanline),
		.mode(mode),
		.frameTick(frameTick),
		.pixels(pixels)
	);

	renderChecker check0 (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.ack(ack),
		.pixels(pixels),
		.expected(expected),
		.errors(errors),
		.checks(checks)
	);

	always #5 clk = ~clk;

	function automatic pixelRow reverseBits(input pixelRow r);
		pixelRow m;
		for (int k = 0; k < 16; k++)
			m[k] = r[15 - k];
		return m;
	endfunction

	// each mask marks the scanlines that carry the line in that form.
	function automatic logic lineHit(input scanRow r, input logic single, input logic dbl,
		input logic dotted, input pixelRow singleRows, input pixelRow dblRows,
		input pixelRow bothRows);
		if (!(single || dbl || dotted))
			return 1'b0;
		if (dbl)
			return single ? bothRows[r] : dblRows[r];
		return singleRows[r];
	endfunction

	function automatic pixelRow expectedRow(input charCode c, input attrWord a, input scanRow s,
		input modeWord m, input int frame);
		scanRow postR;
		scanRow scaledR;
		scanRow effR;
		scanRow bmpR;
		pixelRow r;
		pixelRow t;
		int slant;
		logic lineOn;
		logic under;
		logic strike;
		logic over;
		logic cursorOn;
		logic fnt;
		logic blinkP;
		blinkP = frame[blinkPhaseBit];
		postR = m[modeYPostMirror] ? 4'd15 - s : s;
		scaledR = a[attrYScale] ? postR / 2 : postR;
		effR = a[attrYOffset] ? scaledR ^ 4'd8 : scaledR;
		bmpR = m[modeYPreMirror] ? 4'd15 - effR : effR;
		r = {c, ~c[7:4], c[3:0] ^ bmpR};
		if (m[modeXPreMirror])
			r = reverseBits(r);
		// positive slant moves pixels right.
		slant = 2 - int'(effR) / 4;
		if (a[attrItalic] == a[attrReverseItalic])
			slant = 0;
		else if (a[attrReverseItalic])
			slant = -slant;
		r = (slant >= 0) ? r >> slant : r << -slant;
		if (a[attrBold])
			r = r | (r >> 1) | (a[attrExtraBold] ? r << 1 : 16'h0000);
		if (a[attrXOffset])
			r = {r[7:0], r[15:8]};
		for (int k = 0; k < 16; k++)
			t[k] = r[8 + k / 2];
		if (a[attrXScale])
			r = t;
		lineOn = m[modeLineEnable];
		under = lineOn && lineHit(effR, a[attrUnderline], a[attrDoubleUnderline],
			a[attrDottedUnderline], 16'h2000, 16'hA000, 16'h8000);
		strike = lineOn && lineHit(effR, a[attrStrike], a[attrDoubleStrike],
			a[attrDottedStrike], 16'h0080, 16'h0140, 16'h02A0);
		over = lineOn && lineHit(effR, a[attrOverline], a[attrDoubleOverline],
			a[attrDottedOverline], 16'h0001, 16'h0005, 16'h0004);
		fnt = a[attrFaint] || (under && a[attrDottedUnderline]) ||
			(strike && a[attrDottedStrike]) || (over && a[attrDottedOverline]);
		cursorOn = a[attrCursor] && (frame[cursorPhaseBit] || !m[modeCursorBlink]) &&
			(!(m[modeCursorTop] || m[modeCursorBottom]) || (m[modeCursorTop] && s < 3) ||
			(m[modeCursorBottom] && s > 12));
		if (under || strike || over)
			r = 16'hFFFF;
		if (fnt)
			r = r & ((frame[faintPhaseBit] ^ scaledR[0]) ? 16'h5555 : 16'hAAAA);
		if (a[attrHidden] || (a[attrBlink] && blinkP && m[modeBlinkEnable]))
			r = 16'h0000;
		if (a[attrAlternate] && (blinkP || !m[modeBlinkEnable]))
			r = ~r;
		if (a[attrInverse] ^ cursorOn)
			r = ~r;
		if (m[modeXPostMirror])
			r = reverseBits(r);
		return r;
	endfunction

	// one full four-phase transfer, req stays high for holdCycles extra edges.
	task automatic renderCell(input charCode c, input attrWord a, input scanRow s,
		input modeWord m, input int holdCycles);
		int waited;
		if (timeouts != 0)
			return;
		@(posedge clk);
		code <= c;
		attr <= a;
		scanline <= s;
		mode <= m;
		expected <= expectedRow(c, a, s, m, frames);
		req <= 1'b1;
		waited = 0;
		while (ack !== 1'b1 && waited < ackLimit) begin
			@(negedge clk);
			waited++;
		end
		if (ack !== 1'b1) begin
			$display("Timeout: ack never rose for code %h at scanline %0d", c, s);
			timeouts++;
			return;
		end
		repeat (holdCycles) @(posedge clk);
		@(posedge clk);
		req <= 1'b0;
		waited = 0;
		while (ack !== 1'b0 && waited < ackLimit) begin
			@(negedge clk);
			waited++;
		end
		if (ack !== 1'b0) begin
			$display("Timeout: ack stayed high after req was dropped");
			timeouts++;
		end
	endtask

	task automatic issueTicks(input int n);
		repeat (n) begin
			@(posedge clk);
			frameTick <= 1'b1;
			@(posedge clk);
			frameTick <= 1'b0;
			frames++;
		end
	endtask

	initial begin
		void'($urandom(32'hd295_2f1c));
		arstN = 1'b0;
		req = 1'b0;
		code = '0;
		attr = '0;
		scanline = '0;
		mode = '0;
		frameTick = 1'b0;
		expected = '0;
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		repeat (2) @(posedge clk);
		for (i = 0; i < 40; i++)
			renderCell(charCode'($urandom), '0, scanRow'($urandom), '0, $urandom % 4);
		// each line combination is swept over all sixteen scanlines.
		for (i = 0; i < 24; i++) begin
			lineAttr = attrWord'($urandom) & 24'h03FE00;
			lineMode = modeWord'($urandom) & 10'h020;
			for (row = 0; row < 16; row++)
				renderCell(charCode'($urandom), lineAttr, scanRow'(row), lineMode, 0);
		end
		for (i = 0; i < 80; i++)
			renderCell(charCode'($urandom), attrWord'($urandom) & 24'h78001B,
				scanRow'($urandom), modeWord'($urandom) & 10'h00F, $urandom % 2);
		// requests at frame counts 0, 16, 32 and 48 cover every blink and cursor phase.
		for (stage = 0; stage < 4; stage++) begin
			for (row = 0; row < 16; row++)
				renderCell(charCode'($urandom), attrWord'($urandom) & 24'h040060, scanRow'(row),
					modeWord'($urandom) & 10'h1D0, 0);
			issueTicks(16);
		end
		for (i = 0; i < 120; i++) begin
			issueTicks($urandom % 3);
			renderCell(charCode'($urandom), attrWord'($urandom) & 24'h7FFFFF,
				scanRow'($urandom), modeWord'($urandom) & 10'h1FF, $urandom % 3);
		end
		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- textRenderer.sv
module textRenderer (
	input logic clk,
	input logic arstN,
	input logic req,
	output logic ack,
	input renderPkg::charCode code,
	input renderPkg::attrWord attr,
	input renderPkg::scanRow scanline,
	input renderPkg::modeWord mode,
	input logic frameTick,
	output renderPkg::pixelRow pixels
);

	import renderPkg::*;

	charCode codeQ;
	attrWord attrQ;
	scanRow scanlineQ;
	modeWord modeQ;
	logic romEn;
	logic blinkPhase;
	logic cursorPhase;
	logic faintPhase;
	scanRow bitmapRow;
	scanRow effectRow;
	logic inverseLine;
	logic faintLine;
	logic faintPhaseLine;
	logic solidLine;
	pixelRow glyph;
	pixelRow shapedRow;
	pixelRow styledRow;

	renderCtrl ctrl0 (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.ack(ack),
		.code(code),
		.attr(attr),
		.scanline(scanline),
		.mode(mode),
		.frameTick(frameTick),
		.styledRow(styledRow),
		.codeQ(codeQ),
		.attrQ(attrQ),
		.scanlineQ(scanlineQ),
		.modeQ(modeQ),
		.romEn(romEn),
		.blinkPhase(blinkPhase),
		.cursorPhase(cursorPhase),
		.faintPhase(faintPhase),
		.pixels(pixels)
	);

	glyphRom rom0 (
		.clk(clk),
		.en(romEn),
		.code(codeQ),
		.row(bitmapRow),
		.glyph(glyph)
	);

	lineGen line0 (
		.scanline(scanlineQ),
		.attr(attrQ),
		.mode(modeQ),
		.faintPhase(faintPhase),
		.cursorPhase(cursorPhase),
		.bitmapRow(bitmapRow),
		.effectRow(effectRow),
		.inverseOut(inverseLine),
		.faintOut(faintLine),
		.faintPhaseOut(faintPhaseLine),
		.solidLine(solidLine)
	);

	glyphStyle style0 (
		.glyph(glyph),
		.attr(attrQ),
		.mode(modeQ),
		.effectRow(effectRow),
		.styled(shapedRow)
	);

	inkMask ink0 (
		.styled(shapedRow),
		.attr(attrQ),
		.mode(modeQ),
		.blinkPhase(blinkPhase),
		.inverse(inverseLine),
		.faint(faintLine),
		.faintPhase(faintPhaseLine),
		.solidLine(solidLine),
		.pixels(styledRow)
	);

endmodule
